/* issue_core.f */
core_pkg.sv
reg_scoreboard_file.sv
csr_file.sv
issue_stage.sv
exec_pipe.sv
issue_core.sv
tb_issue_core.sv

/* Makefile */
TOP := tb_issue_core

.PHONY: sim clean

sim:
	verilator --binary -j 0 --assert --top-module $(TOP) -f issue_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* tb_issue_core.sv */
`timescale 1ns/100ps

module tb_issue_core;

    localparam int LATENCY        = 2;
    localparam int N_DIRECTED     = 26;
    localparam int N_RANDOM       = 300;
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 20;
    // Longest wait for the results in flight to come back
    localparam int DRAIN_CYCLES   = 4 * LATENCY + 8;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic              instr_valid_i;
    core_pkg::instr_t  instr_i;
    logic              stall_o;
    core_pkg::wb_t     wb_o;

    // Reference state updated in program order at acceptance
    core_pkg::xlen_t   ref_regs [32];
    core_pkg::xlen_t   ref_mscratch;
    core_pkg::xlen_t   ref_mtvec;
    core_pkg::xlen_t   ref_mepc;
    core_pkg::xlen_t   ref_instret;
    core_pkg::wb_t     exp_q [$];

    integer seed;
    int     errors       = 0;
    int     checks       = 0;
    int     stall_cycles = 0;

    issue_core #(
        .LATENCY (LATENCY)
    ) i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .wb_o          (wb_o)
    );

    always #5 clk_i = ~clk_i;

    // --------------------
    // Reference model
    // --------------------

    function automatic core_pkg::xlen_t csr_model_read(input core_pkg::csr_addr_t addr);
        case (addr)
            core_pkg::CSR_MSCRATCH: return ref_mscratch;
            core_pkg::CSR_MTVEC:    return ref_mtvec;
            core_pkg::CSR_MEPC:     return ref_mepc;
            core_pkg::CSR_INSTRET:  return ref_instret;
            default:                return '0;
        endcase
    endfunction

    task automatic model_apply(input core_pkg::instr_t ins);
        core_pkg::xlen_t a;
        core_pkg::xlen_t res;
        core_pkg::wb_t   exp;
        a = ref_regs[ins.rs1];
        case (ins.op)
            core_pkg::OP_ADD:  res = a + ref_regs[ins.rs2];
            core_pkg::OP_ADDI: res = a + ins.imm;
            default: begin
                // Old value goes to rd while rs1 goes into the CSR
                res = csr_model_read(ins.csr);
                // instret ignores the write
                case (ins.csr)
                    core_pkg::CSR_MSCRATCH: ref_mscratch = a;
                    core_pkg::CSR_MTVEC:    ref_mtvec    = a;
                    core_pkg::CSR_MEPC:     ref_mepc     = a;
                    default: ;
                endcase
            end
        endcase
        ref_instret = ref_instret + 32'd1;
        // x0 destination gives no writeback
        if (ins.rd != '0) begin
            ref_regs[ins.rd] = res;
            exp.valid = 1'b1;
            exp.rd    = ins.rd;
            exp.data  = res;
            exp_q.push_back(exp);
        end
    endtask

    task automatic check_writeback();
        core_pkg::wb_t exp;
        assert (wb_o.rd != '0) else begin
            $display("Writeback to x0 seen at time %0t", $time);
            errors++;
        end
        assert (exp_q.size() != 0) else begin
            $display("Writeback to x%0d at time %0t with no result pending", wb_o.rd, $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            checks++;
            assert ((wb_o.rd == exp.rd) && (wb_o.data == exp.data)) else begin
                $display("FAILED %0t: writeback x%0d = %08h, expected x%0d = %08h",
                         $time, wb_o.rd, wb_o.data, exp.rd, exp.data);
                errors++;
            end
        end
    endtask

    // Sample mid-cycle where all DUT outputs have settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (wb_o.valid) begin
                check_writeback();
            end
            if (stall_o) begin
                stall_cycles++;
            end
            if (instr_valid_i && !stall_o) begin
                model_apply(instr_i);
            end
        end
    end

    // --------------------
    // Drivers
    // --------------------

    // Holds the instruction until the edge that takes it
    task automatic send_instr(input core_pkg::instr_t ins);
        logic taken;
        taken         = 1'b0;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        while (!taken) begin
            @(negedge clk_i);
            taken = !stall_o;
            @(posedge clk_i);
            #1;
        end
        instr_valid_i = 1'b0;
    endtask

    task automatic send_alu(input core_pkg::op_e op, input core_pkg::reg_idx_t rd,
                            input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2,
                            input core_pkg::xlen_t imm);
        core_pkg::instr_t ins;
        ins.op  = op;
        ins.rd  = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = imm;
        ins.csr = '0;
        send_instr(ins);
    endtask

    task automatic send_csr(input core_pkg::reg_idx_t rd, input core_pkg::csr_addr_t csr,
                            input core_pkg::reg_idx_t rs1);
        core_pkg::instr_t ins;
        ins.op  = core_pkg::OP_CSRRW;
        ins.rd  = rd;
        ins.rs1 = rs1;
        ins.rs2 = '0;
        ins.imm = '0;
        ins.csr = csr;
        send_instr(ins);
    endtask

    // Gives up after DRAIN_CYCLES so lost results stay in the queue
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk_i);
        while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(posedge clk_i);
            waited++;
        end
        #1;
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        int                  stall_before;
        logic [31:0]         r;
        core_pkg::reg_idx_t  rd;
        core_pkg::csr_addr_t csr;
        seed          = 32'hfdfb1a86;
        rst_i         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_mscratch = '0;
        ref_mtvec    = '0;
        ref_mepc     = '0;
        ref_instret  = '0;
        repeat (10) @(posedge clk_i);
        #1;
        assert (!stall_o && !wb_o.valid) else begin
            $display("Stall or writeback active straight after reset");
            errors++;
        end
        rst_i = 1'b1;

        // Independent ALU results
        send_alu(core_pkg::OP_ADDI, 5'd1, 5'd0, 5'd0, 32'h0000_0011);
        send_alu(core_pkg::OP_ADDI, 5'd2, 5'd0, 5'd0, 32'h0000_0022);
        send_alu(core_pkg::OP_ADDI, 5'd3, 5'd0, 5'd0, 32'h0000_1000);
        send_alu(core_pkg::OP_ADDI, 5'd4, 5'd0, 5'd0, 32'hffff_fff0);
        wait_drain();
        send_alu(core_pkg::OP_ADD, 5'd5, 5'd1, 5'd2, '0);
        send_alu(core_pkg::OP_ADD, 5'd6, 5'd3, 5'd4, '0);
        send_alu(core_pkg::OP_ADD, 5'd7, 5'd3, 5'd1, '0);
        wait_drain();

        // RAW chain where each source is still pending
        stall_before = stall_cycles;
        send_alu(core_pkg::OP_ADDI, 5'd8, 5'd0, 5'd0, 32'h0000_0001);
        send_alu(core_pkg::OP_ADDI, 5'd8, 5'd8, 5'd0, 32'h0000_0002);
        send_alu(core_pkg::OP_ADD, 5'd9, 5'd8, 5'd8, '0);
        send_alu(core_pkg::OP_ADDI, 5'd10, 5'd9, 5'd0, 32'h0000_0003);
        send_alu(core_pkg::OP_ADD, 5'd11, 5'd10, 5'd9, '0);
        wait_drain();
        assert (stall_cycles > stall_before) else begin
            $display("No stall seen on the read-after-write chain");
            errors++;
        end

        // x0 as destination and as source
        send_alu(core_pkg::OP_ADDI, 5'd0, 5'd1, 5'd0, 32'h0000_0005);
        send_alu(core_pkg::OP_ADD, 5'd0, 5'd1, 5'd2, '0);
        send_alu(core_pkg::OP_ADD, 5'd12, 5'd0, 5'd0, '0);
        send_alu(core_pkg::OP_ADDI, 5'd13, 5'd0, 5'd0, 32'h0000_0007);

        // CSR swaps where the second returns the first one's rs1
        send_csr(5'd15, core_pkg::CSR_MSCRATCH, 5'd1);
        send_csr(5'd16, core_pkg::CSR_MSCRATCH, 5'd2);
        send_csr(5'd17, core_pkg::CSR_MTVEC, 5'd3);
        send_csr(5'd18, core_pkg::CSR_MTVEC, 5'd0);
        send_csr(5'd19, core_pkg::CSR_MEPC, 5'd2);
        send_csr(5'd20, core_pkg::CSR_MEPC, 5'd1);
        send_csr(5'd21, 12'h7c0, 5'd1);
        send_csr(5'd22, 12'h7c0, 5'd2);
        // instret returns the count and drops the write
        send_csr(5'd23, core_pkg::CSR_INSTRET, 5'd1);
        send_csr(5'd24, core_pkg::CSR_INSTRET, 5'd2);
        wait_drain();

        // Random mix over x0..x3 so writers pile up on one rd
        for (int n = 0; n < N_RANDOM; n++) begin
            r  = $random(seed);
            rd = r[6] ? 5'd1 : {3'b000, r[5:4]};
            case (r[13:11])
                3'd0:    csr = core_pkg::CSR_MSCRATCH;
                3'd1:    csr = core_pkg::CSR_MTVEC;
                3'd2:    csr = core_pkg::CSR_MEPC;
                3'd3:    csr = core_pkg::CSR_INSTRET;
                default: csr = 12'h7c0;
            endcase
            if (r[3:0] < 4'd7) begin
                send_alu(core_pkg::OP_ADD, rd, {3'b000, r[8:7]}, {3'b000, r[10:9]}, '0);
            end else if (r[3:0] < 4'd13) begin
                send_alu(core_pkg::OP_ADDI, rd, {3'b000, r[8:7]}, '0, $random(seed));
            end else begin
                send_csr(rd, csr, {3'b000, r[8:7]});
            end
            // Occasional idle cycle
            if (r[15:14] == 2'b00) begin
                @(posedge clk_i);
                #1;
            end
        end
        wait_drain();
        repeat (LATENCY + 2) @(posedge clk_i);

        assert ((exp_q.size() == 0) && !stall_o) else begin
            $display("Results still pending or stall held at the end of the run");
            errors++;
        end
        $display("Writebacks checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, run did not complete", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* issue_core.sv */
`timescale 1ns/100ps

module issue_core #(
    // 1 to 3, keeps the 2-bit pending counters from wrapping
    parameter int unsigned LATENCY = 2
) (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              instr_valid_i,
    input  core_pkg::instr_t  instr_i,

    output logic              stall_o,
    output core_pkg::wb_t     wb_o
);

    // --------------------
    // Internal nets
    // --------------------

    // Read port
    logic                rd_en1;
    logic                rd_en2;
    core_pkg::reg_idx_t  rs1;
    core_pkg::reg_idx_t  rs2;
    core_pkg::xlen_t     rs1_data;
    core_pkg::xlen_t     rs2_data;
    logic                hazard;

    // CSR port
    logic                csr_en;
    core_pkg::csr_addr_t csr_addr;
    core_pkg::xlen_t     csr_wdata;
    core_pkg::xlen_t     csr_rdata;

    // Issue and writeback
    core_pkg::issue_t    issue;
    core_pkg::wb_t       wb;
    logic                claim;

    // Only writers reserve a destination
    assign claim = issue.valid && issue.we;
    assign wb_o  = wb;

    // --------------------
    // Blocks
    // --------------------

    issue_stage i_issue_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .rd_en1_o      (rd_en1),
        .rd_en2_o      (rd_en2),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_i      (hazard),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .csr_en_o      (csr_en),
        .csr_addr_o    (csr_addr),
        .csr_wdata_o   (csr_wdata),
        .csr_rdata_i   (csr_rdata),
        .issue_o       (issue)
    );

    reg_scoreboard_file i_reg_scoreboard_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_en1_i   (rd_en1),
        .rd_en2_i   (rd_en2),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .claim_i    (claim),
        .claim_rd_i (issue.rd),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .hazard_o   (hazard)
    );

    // Every issue counts as retired
    csr_file i_csr_file (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .csr_en_i    (csr_en),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .retire_i    (issue.valid),
        .csr_rdata_o (csr_rdata)
    );

    exec_pipe #(
        .LATENCY (LATENCY)
    ) i_exec_pipe (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .issue_i (issue),
        .wb_o    (wb)
    );

endmodule

/* exec_pipe.sv */
`timescale 1ns/100ps

module exec_pipe #(
    parameter int unsigned LATENCY = 2
) (
    input  logic              clk_i,
    input  logic              rst_i,

    // From issue
    input  core_pkg::issue_t  issue_i,

    // To register file and core output
    output core_pkg::wb_t     wb_o
);

    // Adder result on the issue side
    core_pkg::xlen_t sum;
    logic            launch;

    // Stage registers, index 0 is closest to issue
    logic               valid_q [LATENCY];
    core_pkg::reg_idx_t rd_q    [LATENCY];
    core_pkg::xlen_t    data_q  [LATENCY];

    // --------------------
    // First stage
    // --------------------

    assign sum = issue_i.opa + issue_i.opb;

    // Non-writing entries travel as bubbles
    assign launch = issue_i.valid && issue_i.we;

    // --------------------
    // Shift chain
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int k = 0; k < LATENCY; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else begin
            valid_q[0] <= launch;
            for (int k = 1; k < LATENCY; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    // Payload follows valid without reset
    always_ff @(posedge clk_i) begin
        rd_q[0]   <= issue_i.rd;
        data_q[0] <= sum;
        for (int k = 1; k < LATENCY; k++) begin
            rd_q[k]   <= rd_q[k-1];
            data_q[k] <= data_q[k-1];
        end
    end

    // --------------------
    // Writeback
    // --------------------

    // Last stage, LATENCY cycles after the issue cycle
    assign wb_o.valid = valid_q[LATENCY-1];
    assign wb_o.rd    = rd_q[LATENCY-1];
    assign wb_o.data  = data_q[LATENCY-1];

endmodule

/* issue_stage.sv */
`timescale 1ns/100ps

module issue_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Instruction source
    input  logic                 instr_valid_i,
    input  core_pkg::instr_t     instr_i,
    output logic                 stall_o,

    // Register file read port
    output logic                 rd_en1_o,
    output logic                 rd_en2_o,
    output core_pkg::reg_idx_t   rs1_o,
    output core_pkg::reg_idx_t   rs2_o,
    input  logic                 hazard_i,
    input  core_pkg::xlen_t      rs1_data_i,
    input  core_pkg::xlen_t      rs2_data_i,

    // CSR port
    output logic                 csr_en_o,
    output core_pkg::csr_addr_t  csr_addr_o,
    output core_pkg::xlen_t      csr_wdata_o,
    input  core_pkg::xlen_t      csr_rdata_i,

    // Request to execute
    output core_pkg::issue_t     issue_o
);

    // Decode register
    logic              full_q;
    core_pkg::instr_t  instr_q;

    logic is_add;
    logic is_csrrw;
    logic issue;
    logic accept;

    // --------------------
    // Handshake
    // --------------------

    // Held instruction leaves once its sources are ready
    assign issue   = full_q && !hazard_i;
    assign stall_o = full_q && hazard_i;
    // Empty slot or a slot freed in this cycle
    assign accept  = instr_valid_i && !stall_o;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (issue) begin
            full_q <= 1'b0;
        end
    end

    // Payload only, fullness gates its use
    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
        end
    end

    // --------------------
    // Decode
    // --------------------

    assign is_add   = (instr_q.op == core_pkg::OP_ADD);
    assign is_csrrw = (instr_q.op == core_pkg::OP_CSRRW);

    // Every op reads rs1, only ADD reads rs2
    assign rd_en1_o = full_q;
    assign rd_en2_o = full_q && is_add;
    assign rs1_o    = instr_q.rs1;
    assign rs2_o    = instr_q.rs2;

    // CSRRW swaps rs1 into the CSR
    assign csr_en_o    = issue && is_csrrw;
    assign csr_addr_o  = instr_q.csr;
    assign csr_wdata_o = rs1_data_i;

    // Operand select
    always_comb begin
        issue_o.valid = issue;
        issue_o.rd    = instr_q.rd;
        // x0 destination never claims or writes back
        issue_o.we    = (instr_q.rd != '0);
        issue_o.opa   = is_csrrw ? csr_rdata_i : rs1_data_i;
        case (instr_q.op)
            core_pkg::OP_ADD:  issue_o.opb = rs2_data_i;
            core_pkg::OP_ADDI: issue_o.opb = instr_q.imm;
            default:           issue_o.opb = '0;
        endcase
    end

endmodule

/* csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Access from the issuing CSRRW
    input  logic                 csr_en_i,
    input  core_pkg::csr_addr_t  csr_addr_i,
    input  core_pkg::xlen_t      csr_wdata_i,

    // One pulse per issued instruction
    input  logic                 retire_i,

    // Old value of the addressed CSR
    output core_pkg::xlen_t      csr_rdata_o
);

    // Machine CSRs
    core_pkg::xlen_t mscratch_q;
    core_pkg::xlen_t mtvec_q;
    core_pkg::xlen_t mepc_q;
    // Issued instruction count
    core_pkg::xlen_t instret_q;

    // --------------------
    // Read
    // --------------------

    // Current values, i.e. before this edge's write
    always_comb begin
        case (csr_addr_i)
            core_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            core_pkg::CSR_MTVEC:    csr_rdata_o = mtvec_q;
            core_pkg::CSR_MEPC:     csr_rdata_o = mepc_q;
            core_pkg::CSR_INSTRET:  csr_rdata_o = instret_q;
            // Unmapped reads as zero
            default:                csr_rdata_o = '0;
        endcase
    end

    // --------------------
    // Write and count
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            instret_q  <= '0;
        end else begin
            if (retire_i) begin
                instret_q <= instret_q + core_pkg::xlen_t'(1);
            end
            // instret and unknown addresses ignore writes
            if (csr_en_i) begin
                case (csr_addr_i)
                    core_pkg::CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
                    core_pkg::CSR_MTVEC:    mtvec_q    <= csr_wdata_i;
                    core_pkg::CSR_MEPC:     mepc_q     <= csr_wdata_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* reg_scoreboard_file.sv */
`timescale 1ns/100ps

module reg_scoreboard_file (
    input  logic                clk_i,
    input  logic                rst_i,

    // Source read request from decode
    input  logic                rd_en1_i,
    input  logic                rd_en2_i,
    input  core_pkg::reg_idx_t  rs1_i,
    input  core_pkg::reg_idx_t  rs2_i,

    // Destination claim at issue
    input  logic                claim_i,
    input  core_pkg::reg_idx_t  claim_rd_i,

    // Result from execute
    input  core_pkg::wb_t       wb_i,

    // Source values and stall request
    output core_pkg::xlen_t     rs1_data_o,
    output core_pkg::xlen_t     rs2_data_o,
    output logic                hazard_o
);

    // Architectural state
    core_pkg::xlen_t     regs_q [core_pkg::NUM_REGS];
    core_pkg::pend_cnt_t pend_q [core_pkg::NUM_REGS];

    // Per-register hit vectors for the counter update
    logic [core_pkg::NUM_REGS-1:0] claim_hit;
    logic [core_pkg::NUM_REGS-1:0] release_hit;

    // Writeback into a real register
    logic wb_write;

    // Sources still waiting on a result
    logic pend_rs1;
    logic pend_rs2;

    // --------------------
    // Read side
    // --------------------

    // x0 never gets written, so it reads zero
    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

    // Only enabled, non-x0 sources can block
    assign pend_rs1 = rd_en1_i && (rs1_i != '0) && (pend_q[rs1_i] != '0);
    assign pend_rs2 = rd_en2_i && (rs2_i != '0) && (pend_q[rs2_i] != '0);

    assign hazard_o = pend_rs1 || pend_rs2;

    // --------------------
    // Claim and release
    // --------------------

    assign wb_write = wb_i.valid && (wb_i.rd != '0);

    // Index 0 never matches, its counter stays at zero
    always_comb begin
        for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
            claim_hit[i]   = claim_i && (i != 0) &&
                             (claim_rd_i == core_pkg::reg_idx_t'(i));
            release_hit[i] = wb_write &&
                             (wb_i.rd == core_pkg::reg_idx_t'(i));
        end
    end

    // --------------------
    // State update
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            // Everything back to zero, no preload
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
                pend_q[i] <= '0;
            end
        end else begin
            // Result lands, visible to readers next cycle
            if (wb_write) begin
                regs_q[wb_i.rd] <= wb_i.data;
            end

            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                case ({claim_hit[i], release_hit[i]})
                    // New writer only
                    2'b10: begin
                        pend_q[i] <= pend_q[i] + core_pkg::pend_cnt_t'(1);
                    end
                    // Oldest writer retired
                    2'b01: begin
                        pend_q[i] <= pend_q[i] - core_pkg::pend_cnt_t'(1);
                    end
                    // Claim and release cancel out, or nothing to do
                    default: begin
                        pend_q[i] <= pend_q[i];
                    end
                endcase
            end
        end
    end

endmodule

/* core_pkg.sv */
package core_pkg;

    // --------------------
    // Widths and sizes
    // --------------------

    localparam int unsigned NUM_REGS = 32;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;
    // Writes in flight per register
    typedef logic [1:0]  pend_cnt_t;

    // Supported ops
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_ADDI  = 2'd1,
        OP_CSRRW = 2'd2
    } op_e;

    // --------------------
    // CSR map
    // --------------------

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    // Read only, writes dropped
    localparam csr_addr_t CSR_INSTRET  = 12'hC02;

    // --------------------
    // Stage payloads
    // --------------------

    // Pre-split instruction fields
    typedef struct packed {
        op_e       op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        xlen_t     imm;
        csr_addr_t csr;
    } instr_t;

    // Decoded request handed to execute
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     we;
        xlen_t    opa;
        xlen_t    opb;
    } issue_t;

    // Result returning to the register file
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage
